// ==== src/ldqPkg.sv ====
package ldqPkg;

  localparam int ENTRY_COUNT  = 8;
  localparam int INIT_CYCLES  = 16;
  localparam int STALL_LEVEL  = 6;
  localparam int THREAD_COUNT = 2;

  typedef logic [31:0] lineAddrT;
  typedef logic [31:0] bankMaskT;
  typedef logic [9:0] instIdT;
  typedef logic [3:0] countT;
  typedef logic [ENTRY_COUNT-1:0] entryMaskT;
  typedef logic [$clog2(INIT_CYCLES)-1:0] initCntT;

  // load allocation, one per cycle
  typedef struct packed {
    logic     valid;
    lineAddrT lineAddr;
    bankMaskT banks;
    instIdT   instId;
    logic     thread;
  } allocReqT;

  // store check against all live loads
  typedef struct packed {
    logic     valid;
    lineAddrT lineAddr;
    bankMaskT banks;
  } chkReqT;

  typedef struct packed {
    logic   valid;
    instIdT instId;
  } freeReqT;

  typedef enum logic {
    INIT,
    RUN
  } initStateT;

endpackage

// ==== src/ldqInitFsm.sv ====
`timescale 1ns/1ps

module ldqInitFsm (
  input  logic clk,
  input  logic rst,
  output logic ready
);
  import ldqPkg::*;

  initStateT state;
  initCntT   initCnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= INIT;
      initCnt <= '0;
    end else if (state == INIT) begin
      initCnt <= initCnt + initCntT'(1);
      // last init cycle, queue opens on the next one
      if (initCnt == initCntT'(INIT_CYCLES - 1)) begin
        state <= RUN;
      end
    end
  end

  assign ready = (state == RUN);

  // once open the queue stays open until the next reset
  readyStays: assert property (
    @(posedge clk) disable iff (rst) ready |=> ready
  );

endmodule

// ==== src/ldqOccupancy.sv ====
`timescale 1ns/1ps

module ldqOccupancy (
  input  logic clk,
  input  logic rst,
  input  logic allocGo,
  input  logic allocThread,
  input  logic freeHitNow,
  input  logic freeThread,
  input  logic except,
  input  logic exceptThread,
  output logic doStall
);
  import ldqPkg::*;

  countT cnt [THREAD_COUNT];
  logic [THREAD_COUNT-1:0] incVec;
  logic [THREAD_COUNT-1:0] decVec;
  logic [THREAD_COUNT-1:0] clrVec;
  logic [$bits(countT):0] total;

  always_comb begin
    for (int t = 0; t < THREAD_COUNT; t++) begin
      incVec[t] = allocGo && (allocThread == 1'(t));
      decVec[t] = freeHitNow && (freeThread == 1'(t));
      clrVec[t] = except && (exceptThread == 1'(t));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < THREAD_COUNT; t++) begin
        cnt[t] <= '0;
      end
    end else begin
      for (int t = 0; t < THREAD_COUNT; t++) begin
        // flush wins over a free of the same thread
        if (clrVec[t]) begin
          cnt[t] <= '0;
        end else begin
          cnt[t] <= cnt[t] + countT'(incVec[t]) - countT'(decVec[t]);
        end
      end
    end
  end

  assign total   = cnt[0] + cnt[1];
  assign doStall = (total >= STALL_LEVEL);

  // stall level below entry count keeps the array from overflowing
  totalBounded: assert property (
    @(posedge clk) disable iff (rst) total <= ENTRY_COUNT
  );

endmodule

// ==== src/ldqEntry.sv ====
`timescale 1ns/1ps

module ldqEntry (
  input  logic             clk,
  input  logic             rst,
  input  logic             allocWe,
  input  ldqPkg::allocReqT alloc,
  input  ldqPkg::chkReqT   chk,
  input  ldqPkg::freeReqT  free,
  input  logic             except,
  input  logic             exceptThread,
  output logic             busy,
  output logic             freeMatch,
  output logic             conflict,
  output logic             thread
);
  import ldqPkg::*;

  lineAddrT lineAddr;
  bankMaskT banks;
  instIdT   instId;
  logic     chkHit;
  logic     flushed;

  // load payload, only meaningful while busy
  always_ff @(posedge clk) begin
    if (allocWe) begin
      lineAddr <= alloc.lineAddr;
      banks    <= alloc.banks;
      instId   <= alloc.instId;
      thread   <= alloc.thread;
    end
  end

  // same line and at least one shared bank
  assign chkHit = busy && chk.valid && (chk.lineAddr == lineAddr) &&
                  ((chk.banks & banks) != '0);

  assign freeMatch = busy && free.valid && (free.instId == instId);
  assign flushed   = busy && except && (thread == exceptThread);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      conflict <= 1'b0;
    end else if (allocWe) begin
      busy     <= 1'b1;
      conflict <= 1'b0;
    end else if (flushed || freeMatch) begin
      busy <= 1'b0;
    end else if (chkHit) begin
      conflict <= 1'b1;
    end
  end

  // array must only pick an idle entry
  noAllocOverBusy: assert property (
    @(posedge clk) disable iff (rst) allocWe |-> !busy
  );

endmodule

// ==== src/ldqArray.sv ====
`timescale 1ns/1ps

module ldqArray (
  input  logic             clk,
  input  logic             rst,
  input  logic             allocGo,
  input  ldqPkg::allocReqT alloc,
  input  ldqPkg::chkReqT   chk,
  input  ldqPkg::freeReqT  free,
  input  logic             except,
  input  logic             exceptThread,
  output logic             freeHitNow,
  output logic             freeConflNow,
  output logic             freeThread
);
  import ldqPkg::*;

  entryMaskT busyVec;
  entryMaskT matchVec;
  entryMaskT conflVec;
  entryMaskT threadVec;
  entryMaskT idleVec;
  entryMaskT allocSel;

  // lowest idle entry, all zero when the array is full
  assign idleVec  = ~busyVec;
  assign allocSel = idleVec & (~idleVec + entryMaskT'(1));

  for (genvar i = 0; i < ENTRY_COUNT; i++) begin : entryGen
    ldqEntry entry (
      .clk          (clk),
      .rst          (rst),
      .allocWe      (allocGo && allocSel[i]),
      .alloc        (alloc),
      .chk          (chk),
      .free         (free),
      .except       (except),
      .exceptThread (exceptThread),
      .busy         (busyVec[i]),
      .freeMatch    (matchVec[i]),
      .conflict     (conflVec[i]),
      .thread       (threadVec[i])
    );
  end

  assign freeHitNow   = |matchVec;
  assign freeConflNow = |(matchVec & conflVec);
  assign freeThread   = |(matchVec & threadVec);

  // ids are unique among live loads
  singleFreeMatch: assert property (
    @(posedge clk) disable iff (rst) $onehot0(matchVec)
  );

endmodule

// ==== src/ldq.sv ====
`timescale 1ns/1ps

module ldq (
  input  logic             clk,
  input  logic             rst,
  input  ldqPkg::allocReqT alloc,
  input  ldqPkg::chkReqT   chk,
  input  ldqPkg::freeReqT  free,
  input  logic             except,
  input  logic             exceptThread,
  output logic             ready,
  output logic             doStall,
  output logic             freeDone,
  output logic             freeHit,
  output logic             freeConfl
);
  import ldqPkg::*;

  logic     allocGo;
  chkReqT   chkGated;
  freeReqT  freeGated;
  logic     freeHitNow;
  logic     freeConflNow;
  logic     freeThread;

  ldqInitFsm initFsm (
    .clk   (clk),
    .rst   (rst),
    .ready (ready)
  );

  // requests are dead while init runs
  always_comb begin
    chkGated        = chk;
    chkGated.valid  = chk.valid && ready;
    freeGated       = free;
    freeGated.valid = free.valid && ready;
  end

  // an alloc racing a flush is dropped
  assign allocGo = alloc.valid && ready && !doStall && !except;

  ldqOccupancy occupancy (
    .clk          (clk),
    .rst          (rst),
    .allocGo      (allocGo),
    .allocThread  (alloc.thread),
    .freeHitNow   (freeHitNow),
    .freeThread   (freeThread),
    .except       (except),
    .exceptThread (exceptThread),
    .doStall      (doStall)
  );

  ldqArray array (
    .clk          (clk),
    .rst          (rst),
    .allocGo      (allocGo),
    .alloc        (alloc),
    .chk          (chkGated),
    .free         (freeGated),
    .except       (except),
    .exceptThread (exceptThread),
    .freeHitNow   (freeHitNow),
    .freeConflNow (freeConflNow),
    .freeThread   (freeThread)
  );

  // free response, one cycle after the request
  always_ff @(posedge clk) begin
    if (rst) begin
      freeDone  <= 1'b0;
      freeHit   <= 1'b0;
      freeConfl <= 1'b0;
    end else begin
      freeDone  <= freeGated.valid;
      freeHit   <= freeHitNow;
      freeConfl <= freeConflNow;
    end
  end

endmodule

// ==== dv/ldqTb.sv ====
`timescale 1ns/1ps

module ldqTb;
  import ldqPkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int LINE_BUDGET  = 20;

  logic     clk;
  logic     rst;
  allocReqT alloc;
  chkReqT   chk;
  freeReqT  free;
  logic     except;
  logic     exceptThread;
  logic     ready;
  logic     doStall;
  logic     freeDone;
  logic     freeHit;
  logic     freeConfl;

  // stim operations, one entry per file line
  byte         opList[$];
  logic [31:0] f0List[$];
  logic [31:0] f1List[$];
  logic [31:0] f2List[$];
  logic [31:0] f3List[$];

  int   errors;
  int   checks;
  logic stimLoaded;

  ldq dut0 (
    .clk          (clk),
    .rst          (rst),
    .alloc        (alloc),
    .chk          (chk),
    .free         (free),
    .except       (except),
    .exceptThread (exceptThread),
    .ready        (ready),
    .doStall      (doStall),
    .freeDone     (freeDone),
    .freeHit      (freeHit),
    .freeConfl    (freeConfl)
  );

  always #4 clk = ~clk;

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    errors++;
    $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic addOp(input byte op, input logic [31:0] v0, input logic [31:0] v1,
                       input logic [31:0] v2, input logic [31:0] v3);
    opList.push_back(op);
    f0List.push_back(v0);
    f1List.push_back(v1);
    f2List.push_back(v2);
    f3List.push_back(v3);
  endtask

  task automatic loadStim();
    int          fd;
    int          ch;
    int          rc;
    int          want;
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    fd = $fopen("dv/ldq_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stim file dv/ldq_stim.txt");
      return;
    end
    ch = $fgetc(fd);
    while (ch != -1) begin
      v0 = '0;
      v1 = '0;
      v2 = '0;
      v3 = '0;
      rc = 0;
      want = 0;
      if (ch == "#") begin
        // comment runs to the end of the line
        while (ch != -1 && ch != "\n") begin
          ch = $fgetc(fd);
        end
      end else if (ch == "A") begin
        want = 4;
        rc = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
      end else if (ch == "C") begin
        want = 2;
        rc = $fscanf(fd, "%h %h", v0, v1);
      end else if (ch == "F") begin
        want = 3;
        rc = $fscanf(fd, "%h %h %h", v0, v1, v2);
      end else if (ch == "X" || ch == "S") begin
        want = 1;
        rc = $fscanf(fd, "%h", v0);
      end else if (ch == "W") begin
        want = 1;
        rc = $fscanf(fd, "%d", v0);
      end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
        errors++;
        $display("unknown operation code %c in the stim file", ch);
      end
      if (want != 0) begin
        if (rc != want) begin
          errors++;
          $display("stim operation %c has %0d fields, expected %0d", ch, rc, want);
        end else begin
          addOp(byte'(ch), v0, v1, v2, v3);
        end
      end
      if (ch != -1) begin
        ch = $fgetc(fd);
      end
    end
    $fclose(fd);
  endtask

  task automatic driveIdle();
    alloc.valid  <= 1'b0;
    chk.valid    <= 1'b0;
    free.valid   <= 1'b0;
    except       <= 1'b0;
    exceptThread <= 1'b0;
  endtask

  // one idle edge, then look at the registered free response
  task automatic finishOp(input logic isFree, input logic expHit, input logic expConfl);
    @(posedge clk);
    driveIdle();
    @(negedge clk);
    checks++;
    if (freeDone !== isFree) begin
      reportMismatch("freeDone", freeDone, isFree);
    end
    if (isFree) begin
      checks += 2;
      if (freeHit !== expHit) begin
        reportMismatch("freeHit", freeHit, expHit);
      end
      if (freeConfl !== expConfl) begin
        reportMismatch("freeConfl", freeConfl, expConfl);
      end
    end
  endtask

  task automatic runOp(input int idx);
    byte         op;
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    op = opList[idx];
    v0 = f0List[idx];
    v1 = f1List[idx];
    v2 = f2List[idx];
    v3 = f3List[idx];
    case (op)
      "A": begin
        @(posedge clk);
        driveIdle();
        alloc.valid    <= 1'b1;
        alloc.thread   <= v0[0];
        alloc.instId   <= instIdT'(v1);
        alloc.lineAddr <= v2;
        alloc.banks    <= v3;
        finishOp(1'b0, 1'b0, 1'b0);
      end
      "C": begin
        @(posedge clk);
        driveIdle();
        chk.valid    <= 1'b1;
        chk.lineAddr <= v0;
        chk.banks    <= v1;
        finishOp(1'b0, 1'b0, 1'b0);
      end
      "F": begin
        @(posedge clk);
        driveIdle();
        free.valid  <= 1'b1;
        free.instId <= instIdT'(v0);
        finishOp(1'b1, v1[0], v2[0]);
      end
      "X": begin
        @(posedge clk);
        driveIdle();
        except       <= 1'b1;
        exceptThread <= v0[0];
        finishOp(1'b0, 1'b0, 1'b0);
      end
      "W": begin
        repeat (v0) begin
          @(posedge clk);
          driveIdle();
        end
        @(negedge clk);
      end
      "S": begin
        checks++;
        if (doStall !== v0[0]) begin
          reportMismatch("doStall", doStall, v0[0]);
        end
      end
      default: begin
        errors++;
        $display("operation %0d has no handler", idx);
      end
    endcase
  endtask

  // ready must open exactly INIT_CYCLES edges after reset is released
  initial begin : readyMonitor
    logic expReady;
    @(negedge rst);
    for (int k = 0; k <= INIT_CYCLES + 2; k++) begin
      @(negedge clk);
      expReady = (k >= INIT_CYCLES);
      checks++;
      if (ready !== expReady) begin
        reportMismatch("ready", ready, expReady);
      end
    end
  end

  initial begin : watchdog
    int limitCycles;
    wait (stimLoaded === 1'b1);
    limitCycles = opList.size() * LINE_BUDGET + INIT_CYCLES + RESET_CYCLES;
    repeat (limitCycles) @(posedge clk);
    $display("timeout: stim run did not finish within %0d cycles", limitCycles);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : mainFlow
    clk          = 1'b0;
    rst          = 1'b1;
    alloc        = '0;
    chk          = '0;
    free         = '0;
    except       = 1'b0;
    exceptThread = 1'b0;
    errors       = 0;
    checks       = 0;
    stimLoaded   = 1'b0;
    loadStim();
    stimLoaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < opList.size(); i++) begin
      runOp(i);
    end
    repeat (2) @(posedge clk);
    $display("%0d errors in %0d checks over %0d stim operations",
             errors, checks, opList.size());
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
src/ldqPkg.sv
src/ldqInitFsm.sv
src/ldqOccupancy.sv
src/ldqEntry.sv
src/ldqArray.sv
src/ldq.sv
dv/ldqTb.sv

// ==== dv/ldq_stim.txt ====
# A thread id addr banks | C addr banks | F id expHit expConfl
# X thread | W cycles (decimal) | S expDoStall ; all other fields hex
# alloc during init is lost
A 0 001 00001000 0000000f
W 20
F 001 0 0
S 0
# store checks against three live loads
A 0 010 00002000 000000f0
A 1 011 00002000 0000000f
A 0 012 00003000 000000f0
# same line, overlapping banks only with 010
C 00002000 00000030
# same line but disjoint banks
C 00003000 0000000f
# other line with overlapping banks
C 00003040 000000f0
F 010 1 1
F 011 1 0
F 012 1 0
# id not in the queue
F 3ff 0 0
F 010 0 0
S 0
# fill up to the stall level, entry 0 is reused with a clean flag
A 0 020 00005000 00000001
A 0 021 00005040 00000002
A 1 022 00005080 00000004
A 1 023 000050c0 00000008
A 0 024 00005100 00000010
S 0
A 1 025 00005140 00000020
S 1
# dropped while stalled
A 0 026 00005180 00000040
F 026 0 0
S 1
F 020 1 0
S 0
A 0 027 000051c0 00000080
S 1
# flush thread 1, thread 0 keeps 021 024 027
X 1
S 0
F 022 0 0
F 023 0 0
F 025 0 0
F 021 1 0
S 0
A 1 030 00006000 00000100
C 00006000 00000100
F 030 1 1
F 024 1 0
F 027 1 0
S 0
W 4
